// File: common/rename_pkg.sv
`default_nettype none

// Shared sizes and index types for register rename
package rename_pkg;

	// Register file sizes
	localparam int NUM_ARCH_REGS = 32; // Architectural, as seen by the ISA
	localparam int NUM_PHYS_REGS = 64; // Physical, in the core's register file

	// Index widths follow from the sizes
	localparam int ARCH_IDX_W = $clog2(NUM_ARCH_REGS);
	localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS);

	// Architectural register index, 5 bits
	typedef logic [ARCH_IDX_W-1:0] arch_reg_t;

	// Physical register index, 6 bits
	typedef logic [PHYS_IDX_W-1:0] phys_reg_t;

	// Every architectural register needs a physical home at reset
	localparam int RESET_FREE_COUNT = NUM_PHYS_REGS - NUM_ARCH_REGS;

endpackage

`default_nettype wire

// File: rename/free_list.sv
`timescale 1ns/100ps
`default_nettype none

// FIFO of physical register numbers not currently mapped
// Preloaded at reset, refilled by commit, drained by allocation
module free_list #(
	parameter int FIRST_FREE = 32, // First preloaded register number
	parameter int FREE_COUNT = 32  // Number of registers preloaded
) (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 push,      // Commit returns a register
	input  wire rename_pkg::phys_reg_t push_preg,
	input  wire logic                 pop,       // Allocation takes the head
	output rename_pkg::phys_reg_t     free_preg, // Head entry, fall-through
	output logic                      free_empty
);

	import rename_pkg::*;

	// Capacity is the whole physical file, the most that can ever be free
	localparam int DEPTH = NUM_PHYS_REGS;
	localparam int AW    = $clog2(DEPTH);

	typedef logic [AW-1:0] ptr_t;
	typedef logic [AW:0]   cnt_t; // One extra bit to hold DEPTH

	phys_reg_t mem [DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	cnt_t count_next;

	logic full;
	logic do_push;
	logic do_pop;

	// Wraps at DEPTH, also for a capacity that is not a power of two
	function automatic ptr_t next_ptr(input ptr_t p);
		if (p == ptr_t'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full       = (count == cnt_t'(DEPTH));
	assign free_empty = (count == '0);

	assign do_push = push && !full;       // Dropped when full
	assign do_pop  = pop && !free_empty;  // Ignored when empty

	// Push and pop together leave the count alone
	always_comb begin
		count_next = count;
		case ({do_push, do_pop})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	assign free_preg = mem[rd_ptr]; // No read latency

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= ptr_t'(FREE_COUNT % DEPTH); // Next slot after the preload
			count  <= cnt_t'(FREE_COUNT);
			// Consecutive numbers from FIRST_FREE
			for (int i = 0; i < FREE_COUNT; i++) begin
				mem[i] <= phys_reg_t'(FIRST_FREE + i);
			end
		end else begin
			count <= count_next;
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push) begin
				mem[wr_ptr] <= push_preg;
				wr_ptr      <= next_ptr(wr_ptr);
			end
		end
	end

	// A correct machine never overflows or underflows the list
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		!(push && full) && !(pop && free_empty))
		else $error("free_list: push when full or pop when empty");

endmodule

`default_nettype wire

// File: rename/map_table.sv
`timescale 1ns/100ps
`default_nettype none

// Architectural to physical mapping
// Three combinational reads, one write per cycle
module map_table (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire rename_pkg::arch_reg_t src1,
	input  wire rename_pkg::arch_reg_t src2,
	input  wire rename_pkg::arch_reg_t dst,       // Read old mapping and write new
	output rename_pkg::phys_reg_t      src1_preg,
	output rename_pkg::phys_reg_t      src2_preg,
	output rename_pkg::phys_reg_t      old_preg,  // Mapping being replaced
	input  wire logic                  map_we,
	input  wire rename_pkg::phys_reg_t new_preg
);

	import rename_pkg::*;

	// One physical index per architectural register
	phys_reg_t map [NUM_ARCH_REGS];

	// Reads see the table before this edge's write
	// So a source equal to the destination gets the old mapping
	assign src1_preg = map[src1];
	assign src2_preg = map[src2];
	assign old_preg  = map[dst];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// Identity, arch i lives in phys i
			for (int i = 0; i < NUM_ARCH_REGS; i++) begin
				map[i] <= phys_reg_t'(i);
			end
		end else if (map_we) begin
			map[dst] <= new_preg; // Visible to the next instruction
		end
	end

endmodule

`default_nettype wire

// File: rename/rename_stage.sv
`timescale 1ns/100ps
`default_nettype none

// Rename pipeline stage
// Accepts from decode, allocates a destination, holds the result
// in one output register until the next stage takes it
module rename_stage (
	input  wire logic                  clk,
	input  wire logic                  reset,

	// Decode side
	input  wire logic                  dec_valid,
	output logic                       dec_ready,
	input  wire logic                  dec_dst_valid, // Instruction writes a register

	// Mapping lookups for the instruction at the decode side
	input  wire rename_pkg::phys_reg_t src1_preg,
	input  wire rename_pkg::phys_reg_t src2_preg,
	input  wire rename_pkg::phys_reg_t old_preg,

	// Free list
	input  wire rename_pkg::phys_reg_t free_preg,
	input  wire logic                  free_empty,
	output logic                       free_pop,

	output logic                       map_we, // Record dst -> free_preg

	// Next stage
	output logic                       ren_valid,
	input  wire logic                  ren_ready,
	output rename_pkg::phys_reg_t      ren_src1,
	output rename_pkg::phys_reg_t      ren_src2,
	output rename_pkg::phys_reg_t      ren_dst,
	output rename_pkg::phys_reg_t      ren_old_dst,
	output logic                       ren_dst_valid
);

	import rename_pkg::*;

	logic out_free; // Output register empty or draining this edge
	logic accept;   // Decode handshake completes
	logic alloc;    // Accepted and needs a destination

	phys_reg_t alloc_preg;
	phys_reg_t alloc_old;

	assign out_free = !ren_valid || ren_ready;

	// No destination means no need for a free register
	assign dec_ready = out_free && (!dec_dst_valid || !free_empty);

	assign accept = dec_valid && dec_ready;
	assign alloc  = accept && dec_dst_valid;

	assign free_pop = alloc;
	assign map_we   = alloc;

	// Destination fields read as zero when nothing is written
	assign alloc_preg = dec_dst_valid ? free_preg : '0;
	assign alloc_old  = dec_dst_valid ? old_preg : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			ren_valid <= 1'b0;
		else if (out_free)
			ren_valid <= accept; // Refill or go empty
	end

	// Payload loads only on accept, otherwise it holds
	always_ff @(posedge clk) begin
		if (accept) begin
			ren_src1      <= src1_preg;
			ren_src2      <= src2_preg;
			ren_dst       <= alloc_preg;
			ren_old_dst   <= alloc_old;
			ren_dst_valid <= dec_dst_valid;
		end
	end

	// Back-pressure holds the output word unchanged
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		(ren_valid && !ren_ready) |=> (ren_valid
			&& $stable({ren_src1, ren_src2, ren_dst, ren_old_dst, ren_dst_valid})))
		else $error("rename_stage: output changed under back-pressure");

	// Never ask an empty free list for a register
	a_pop_nonempty: assert property (@(posedge clk) disable iff (reset)
		free_pop |-> !free_empty)
		else $error("rename_stage: pop from empty free list");

endmodule

`default_nettype wire

// File: rtl/rename_top.sv
`timescale 1ns/100ps
`default_nettype none

// Register rename, one instruction per cycle
module rename_top #(
	parameter int FIRST_FREE = rename_pkg::NUM_ARCH_REGS,   // Just above the identity map
	parameter int FREE_COUNT = rename_pkg::RESET_FREE_COUNT // Unmapped at reset
) (
	input  wire logic                  clk,
	input  wire logic                  reset,

	// Decode
	input  wire logic                  dec_valid,
	output logic                       dec_ready,
	input  wire rename_pkg::arch_reg_t dec_src1,
	input  wire rename_pkg::arch_reg_t dec_src2,
	input  wire rename_pkg::arch_reg_t dec_dst,
	input  wire logic                  dec_dst_valid,

	// Renamed output
	output logic                       ren_valid,
	input  wire logic                  ren_ready,
	output rename_pkg::phys_reg_t      ren_src1,
	output rename_pkg::phys_reg_t      ren_src2,
	output rename_pkg::phys_reg_t      ren_dst,
	output rename_pkg::phys_reg_t      ren_old_dst,
	output logic                       ren_dst_valid,

	// Commit frees an old physical register
	input  wire logic                  commit_valid,
	input  wire rename_pkg::phys_reg_t commit_preg
);

	import rename_pkg::*;

	phys_reg_t src1_preg;
	phys_reg_t src2_preg;
	phys_reg_t old_preg;
	phys_reg_t free_preg; // Next register to hand out
	logic      free_empty;
	logic      free_pop;
	logic      map_we;

	free_list #(
		.FIRST_FREE (FIRST_FREE),
		.FREE_COUNT (FREE_COUNT)
	) free_list_i (
		.clk        (clk),
		.reset      (reset),
		.push       (commit_valid),
		.push_preg  (commit_preg),
		.pop        (free_pop),
		.free_preg  (free_preg),
		.free_empty (free_empty)
	);

	map_table map_table_i (
		.clk       (clk),
		.reset     (reset),
		.src1      (dec_src1),
		.src2      (dec_src2),
		.dst       (dec_dst),
		.src1_preg (src1_preg),
		.src2_preg (src2_preg),
		.old_preg  (old_preg),
		.map_we    (map_we),
		.new_preg  (free_preg) // Same register the free list pops
	);

	rename_stage rename_stage_i (
		.clk           (clk),
		.reset         (reset),
		.dec_valid     (dec_valid),
		.dec_ready     (dec_ready),
		.dec_dst_valid (dec_dst_valid),
		.src1_preg     (src1_preg),
		.src2_preg     (src2_preg),
		.old_preg      (old_preg),
		.free_preg     (free_preg),
		.free_empty    (free_empty),
		.free_pop      (free_pop),
		.map_we        (map_we),
		.ren_valid     (ren_valid),
		.ren_ready     (ren_ready),
		.ren_src1      (ren_src1),
		.ren_src2      (ren_src2),
		.ren_dst       (ren_dst),
		.ren_old_dst   (ren_old_dst),
		.ren_dst_valid (ren_dst_valid)
	);

endmodule

`default_nettype wire

// File: bench/rename_tb.sv
`timescale 1ns/100ps
`default_nettype none

// Table-driven testbench for rename_top with a reference model
module rename_tb;

	import rename_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	localparam int FIRST_FREE   = NUM_ARCH_REGS;
	localparam int FREE_COUNT   = NUM_PHYS_REGS - NUM_ARCH_REGS;

	typedef enum logic [1:0] {K_IDLE, K_DECODE, K_COMMIT} kind_t;

	// One table step, exp_ready of 2 means not checked
	typedef struct packed {
		kind_t     kind;
		arch_reg_t src1;
		arch_reg_t src2;
		arch_reg_t dst;
		logic      dst_valid;
		phys_reg_t commit_preg;
		logic      ren_ready;
		logic [1:0] exp_ready;
	} row_t;

	// Expected output word
	typedef struct packed {
		phys_reg_t src1;
		phys_reg_t src2;
		phys_reg_t dst;
		phys_reg_t old_dst;
		logic      dst_valid;
	} ren_t;

	logic      clk, reset;
	logic      dec_valid, dec_ready, dec_dst_valid;
	arch_reg_t dec_src1, dec_src2, dec_dst;
	logic      ren_valid, ren_ready, ren_dst_valid;
	phys_reg_t ren_src1, ren_src2, ren_dst, ren_old_dst;
	logic      commit_valid;
	phys_reg_t commit_preg;

	row_t      rows[$];
	phys_reg_t map_m [NUM_ARCH_REGS]; // Model map table
	phys_reg_t free_q[$];             // Model free list
	ren_t      exp_q[$];              // Words waiting at the output
	integer    seed = 43671;

	rename_top #(
		.FIRST_FREE (FIRST_FREE),
		.FREE_COUNT (FREE_COUNT)
	) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_preg(input string name, input phys_reg_t got, input phys_reg_t exp);
		if (got !== exp)
			abort_run($sformatf("error %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error %0d ns: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic add_row(input kind_t k, input int s1, input int s2, input int d,
			input logic dv, input int cp, input logic rr, input int er);
		rows.push_back('{k, arch_reg_t'(s1), arch_reg_t'(s2), arch_reg_t'(d), dv,
			phys_reg_t'(cp), rr, 2'(er)});
	endtask

	task automatic build_table();
		add_row(K_DECODE, 3, 7, 0, 0, 0, 1, 1);   // Identity after reset
		add_row(K_DECODE, 0, 31, 0, 0, 0, 1, 1);
		add_row(K_DECODE, 1, 2, 5, 1, 0, 1, 1);   // Gets FIRST_FREE
		add_row(K_DECODE, 5, 4, 6, 1, 0, 1, 1);
		add_row(K_DECODE, 6, 5, 5, 1, 0, 1, 1);   // Old dst is the first allocation
		add_row(K_DECODE, 5, 6, 0, 0, 0, 1, 1);   // Sees the newest mappings
		add_row(K_DECODE, 7, 7, 7, 1, 0, 1, 1);   // Own dst reads the old one
		// Random fillers use up the rest of the preload
		for (int i = 0; i < FREE_COUNT - 4; i++)
			add_row(K_DECODE, $random(seed), $random(seed), $random(seed), 1, 0, 1, 2);
		add_row(K_DECODE, 1, 2, 8, 1, 0, 1, 0);   // Free list empty, stalls
		add_row(K_DECODE, 8, 9, 0, 0, 0, 1, 1);   // No dst still goes
		add_row(K_COMMIT, 0, 0, 0, 0, 5, 1, 2);
		add_row(K_DECODE, 3, 4, 9, 1, 0, 1, 1);   // Committed reg comes back
		add_row(K_COMMIT, 0, 0, 0, 0, 6, 1, 2);
		add_row(K_COMMIT, 0, 0, 0, 0, 32, 1, 2);
		add_row(K_IDLE, 0, 0, 0, 0, 0, 1, 2);     // Drain
		add_row(K_DECODE, 9, 5, 10, 1, 0, 0, 1);  // Loads, then held
		add_row(K_DECODE, 10, 1, 11, 1, 0, 0, 0); // Blocked by back-pressure
		add_row(K_IDLE, 0, 0, 0, 0, 0, 0, 2);
		add_row(K_DECODE, 10, 1, 11, 1, 0, 1, 1); // Drain and accept together
		add_row(K_DECODE, 10, 11, 0, 0, 0, 1, 1);
		add_row(K_IDLE, 0, 0, 0, 0, 0, 1, 2);
		add_row(K_IDLE, 0, 0, 0, 0, 0, 1, 2);
	endtask

	// Model step for one edge, sampled just before it
	task automatic apply_row(input row_t r);
		ren_t e;
		logic exp_rdy;
		exp_rdy = (exp_q.size() == 0 || r.ren_ready) && (!r.dst_valid || free_q.size() != 0);
		if (r.kind == K_DECODE) begin
			check_flag("dec_ready", dec_ready, exp_rdy);
			if (r.exp_ready != 2)
				check_flag("dec_ready vs table", dec_ready, r.exp_ready[0]);
		end
		check_flag("ren_valid", ren_valid, exp_q.size() != 0);
		if (ren_valid) begin // Every cycle, so a hold is checked too
			check_preg("ren_src1", ren_src1, exp_q[0].src1);
			check_preg("ren_src2", ren_src2, exp_q[0].src2);
			check_flag("ren_dst_valid", ren_dst_valid, exp_q[0].dst_valid);
			if (exp_q[0].dst_valid) begin
				check_preg("ren_dst", ren_dst, exp_q[0].dst);
				check_preg("ren_old_dst", ren_old_dst, exp_q[0].old_dst);
			end
			if (r.ren_ready)
				void'(exp_q.pop_front());
		end
		if (r.kind == K_DECODE && exp_rdy) begin
			e = '{map_m[r.src1], map_m[r.src2], '0, '0, r.dst_valid}; // Reads before write
			if (r.dst_valid) begin
				e.dst        = free_q.pop_front();
				e.old_dst    = map_m[r.dst];
				map_m[r.dst] = e.dst;
			end
			exp_q.push_back(e);
		end
		if (r.kind == K_COMMIT)
			free_q.push_back(r.commit_preg); // After the pop, usable next edge
	endtask

	initial begin
		build_table();
		for (int i = 0; i < NUM_ARCH_REGS; i++)
			map_m[i] = phys_reg_t'(i);
		for (int i = 0; i < FREE_COUNT; i++)
			free_q.push_back(phys_reg_t'(FIRST_FREE + i));
		reset         = 1'b1;
		dec_valid     = 1'b0;
		dec_src1      = '0;
		dec_src2      = '0;
		dec_dst       = '0;
		dec_dst_valid = 1'b0;
		ren_ready     = 1'b0;
		commit_valid  = 1'b0;
		commit_preg   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
		foreach (rows[i]) begin
			@(posedge clk);
			#1; // Drive clear of the edge
			dec_valid     = (rows[i].kind == K_DECODE);
			dec_src1      = rows[i].src1;
			dec_src2      = rows[i].src2;
			dec_dst       = rows[i].dst;
			dec_dst_valid = rows[i].dst_valid && (rows[i].kind == K_DECODE);
			commit_valid  = (rows[i].kind == K_COMMIT);
			commit_preg   = rows[i].commit_preg;
			ren_ready     = rows[i].ren_ready;
			#5 apply_row(rows[i]); // Settled, 2 ns before the next edge
		end
		if (exp_q.size() != 0)
			abort_run("Output words were left undelivered at the end of the table");
		else begin
			$display("Done: no errors");
			$finish;
		end
	end

	// Watchdog sized from the table length
	initial begin
		#1;
		#((rows.size() + RESET_CYCLES + 20) * CLK_PERIOD);
		abort_run("The run timed out before the table was finished");
	end

endmodule

`default_nettype wire

// File: vlog.f
common/rename_pkg.sv
rename/free_list.sv
rename/map_table.sv
rename/rename_stage.sv
rtl/rename_top.sv
bench/rename_tb.sv

// File: Bender.yml
package:
  name: rename

dependencies: {}

sources:
  - common/rename_pkg.sv
  - rename/free_list.sv
  - rename/map_table.sv
  - rename/rename_stage.sv
  - rtl/rename_top.sv
  - target: test
    files:
      - bench/rename_tb.sv

# Top modules: rename_top for synthesis, rename_tb for simulation
